// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= controlUnitTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIMARGS   ?= +verilator+error+limit+100
PASS_MSG  ?= Test OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SIMARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(BUILD_DIR)/V$(TOP) $(SIMARGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== logic/controlUnit.sv ====
`timescale 1ns/1ns

module controlUnit import ctrlPkg::*; (
  input  logic     clk,
  input  logic     reset_in,
  input  logic     updateUc,   // Branch outcome from the ALU
  input  opcode_t  opcode,
  input  funct_t   funct,
  output logic     resetOut,
  output logic     pcWrite,
  output logic     irWrite,
  output logic     aluOutWrite,
  output logic     regFileWrite,
  output logic     aRegWrite,
  output logic     bRegWrite,
  output muxSel_t  regDstSel,
  output muxSel_t  pcSrcSel,
  output muxSel_t  aluSrcASel,
  output muxSel_t  aluSrcBSel,
  output dataSel_t regDataSel,
  output aluOp_t   aluOp
);

  instClass_t instClass;
  aluOp_t     execAluOp;
  seqState_t  seqState;
  stepCount_t step;
  instClass_t heldClass;
  aluOp_t     heldAluOp;

  instDecoder u_decoder (
    .opcode   (opcode),
    .funct    (funct),
    .instClass(instClass),
    .execAluOp(execAluOp)
  );

  cycleSequencer u_sequencer (
    .clk      (clk),
    .reset_in (reset_in),
    .updateUc (updateUc),
    .instClass(instClass),
    .execAluOp(execAluOp),
    .seqState (seqState),
    .step     (step),
    .heldClass(heldClass),
    .heldAluOp(heldAluOp)
  );

  // Live class needed at the last fetch step for jumps
  signalGenerator u_generator (
    .clk         (clk),
    .reset_in    (reset_in),
    .seqState    (seqState),
    .step        (step),
    .heldClass   (heldClass),
    .heldAluOp   (heldAluOp),
    .instClass   (instClass),
    .resetOut    (resetOut),
    .pcWrite     (pcWrite),
    .irWrite     (irWrite),
    .aluOutWrite (aluOutWrite),
    .regFileWrite(regFileWrite),
    .aRegWrite   (aRegWrite),
    .bRegWrite   (bRegWrite),
    .regDstSel   (regDstSel),
    .pcSrcSel    (pcSrcSel),
    .aluSrcASel  (aluSrcASel),
    .aluSrcBSel  (aluSrcBSel),
    .regDataSel  (regDataSel),
    .aluOp       (aluOp)
  );

endmodule

// ==== logic/ctrlPkg.sv ====
package ctrlPkg;

  // Instruction fields
  typedef logic [5:0] opcode_t;
  typedef logic [5:0] funct_t;

  // Datapath control fields
  typedef logic [3:0] aluOp_t;
  typedef logic [1:0] muxSel_t;
  typedef logic [2:0] dataSel_t;

  typedef logic [2:0] stepCount_t;  // Execute step counter

  typedef enum logic [3:0] {
    AluReg,
    ShiftVar,
    ShiftImm,
    JumpReg,
    Jump,
    JumpLink,
    AddImm,
    Branch,
    Unknown
  } instClass_t;

  typedef enum logic [1:0] {
    Reset,
    Fetch,
    Execute
  } seqState_t;

  // Opcodes
  localparam opcode_t OP_RTYPE = 6'h00;
  localparam opcode_t OP_J     = 6'h02;
  localparam opcode_t OP_JAL   = 6'h03;
  localparam opcode_t OP_BEQ   = 6'h04;
  localparam opcode_t OP_BNE   = 6'h05;
  localparam opcode_t OP_BLE   = 6'h06;
  localparam opcode_t OP_BGT   = 6'h07;
  localparam opcode_t OP_ADDI  = 6'h08;
  localparam opcode_t OP_ADDIU = 6'h09;

  // R-type functs
  localparam funct_t FN_SLL  = 6'h00;
  localparam funct_t FN_SRL  = 6'h02;
  localparam funct_t FN_SRA  = 6'h03;
  localparam funct_t FN_SLLV = 6'h04;
  localparam funct_t FN_SRAV = 6'h07;
  localparam funct_t FN_JR   = 6'h08;
  localparam funct_t FN_ADD  = 6'h20;
  localparam funct_t FN_SUB  = 6'h22;
  localparam funct_t FN_AND  = 6'h24;
  localparam funct_t FN_SLT  = 6'h2A;

  // ALU operation codes
  localparam aluOp_t ALU_PASS_A  = 4'h0;
  localparam aluOp_t ALU_ADD     = 4'h1;
  localparam aluOp_t ALU_SUB     = 4'h2;
  localparam aluOp_t ALU_AND     = 4'h3;
  localparam aluOp_t ALU_SHL_IMM = 4'h5;
  localparam aluOp_t ALU_SHL_VAR = 4'h6;
  localparam aluOp_t ALU_SHR_IMM = 4'h7;
  localparam aluOp_t ALU_SRA_IMM = 4'h8;
  localparam aluOp_t ALU_SRA_VAR = 4'h9;
  localparam aluOp_t ALU_SLT     = 4'hA;
  localparam aluOp_t ALU_BEQ     = 4'hB;
  localparam aluOp_t ALU_BNE     = 4'hC;
  localparam aluOp_t ALU_BLE     = 4'hD;
  localparam aluOp_t ALU_BGT     = 4'hE;

  // PC source mux
  localparam muxSel_t PC_FROM_ALU    = 2'd0;
  localparam muxSel_t PC_FROM_ALUOUT = 2'd1;
  localparam muxSel_t PC_FROM_JUMP   = 2'd2;

  // ALU operand muxes
  localparam muxSel_t SRCA_PC     = 2'd0;
  localparam muxSel_t SRCA_REG    = 2'd1;
  localparam muxSel_t SRCB_REG    = 2'd0;
  localparam muxSel_t SRCB_FOUR   = 2'd1;
  localparam muxSel_t SRCB_IMM    = 2'd2;
  localparam muxSel_t SRCB_BRANCH = 2'd3;  // Shifted offset

  // Register file write port
  localparam muxSel_t  DST_RT     = 2'd0;
  localparam muxSel_t  DST_RD     = 2'd1;
  localparam muxSel_t  DST_RA     = 2'd3;
  localparam dataSel_t WDATA_ALU  = 3'd0;
  localparam dataSel_t WDATA_LINK = 3'd6;

  localparam int FETCH_STEPS = 3;

endpackage

// ==== logic/cycleSequencer.sv ====
`timescale 1ns/1ns

module cycleSequencer import ctrlPkg::*; (
  input  logic       clk,
  input  logic       reset_in,
  input  logic       updateUc,
  input  instClass_t instClass,
  input  aluOp_t     execAluOp,
  output seqState_t  seqState,
  output stepCount_t step,
  output instClass_t heldClass,
  output aluOp_t     heldAluOp
);

  logic       lastFetch;
  logic       execDone;
  stepCount_t lastStep;

  assign lastFetch = (step == stepCount_t'(FETCH_STEPS - 1));

  // Final execute step per class
  always_comb begin
    case (heldClass)
      ShiftVar: lastStep = 3'd5;  // Extra shifter cycle
      JumpLink: lastStep = 3'd1;
      default:  lastStep = 3'd4;
    endcase
  end

  // Branch not taken stops after the compare
  assign execDone = (step == lastStep) ||
                    (heldClass == Branch && step == 3'd2 && !updateUc);

  always_ff @(posedge clk) begin
    if (reset_in) begin
      seqState <= Reset;
      step     <= '0;
    end else begin
      case (seqState)
        Reset: begin
          seqState <= Fetch;
          step     <= '0;
        end
        Fetch: begin
          if (lastFetch) begin
            step <= '0;
            // j and undecoded opcodes have no execute phase
            if (instClass == Jump || instClass == Unknown) seqState <= Fetch;
            else seqState <= Execute;
          end else begin
            step <= step + 3'd1;
          end
        end
        Execute: begin
          if (execDone) begin
            seqState <= Fetch;
            step     <= '0;
          end else begin
            step <= step + 3'd1;
          end
        end
        default: begin
          seqState <= Reset;
          step     <= '0;
        end
      endcase
    end
  end

  // Instruction captured once IR is stable
  always_ff @(posedge clk) begin
    if (seqState == Fetch && lastFetch) begin
      heldClass <= instClass;
      heldAluOp <= execAluOp;
    end
  end

endmodule

// ==== logic/instDecoder.sv ====
`timescale 1ns/1ns

module instDecoder import ctrlPkg::*; (
  input  opcode_t    opcode,
  input  funct_t     funct,
  output instClass_t instClass,
  output aluOp_t     execAluOp
);

  always_comb begin
    instClass = Unknown;  // Falls back to fetch
    execAluOp = ALU_PASS_A;
    case (opcode)
      OP_RTYPE: begin
        case (funct)
          FN_ADD: begin
            instClass = AluReg;
            execAluOp = ALU_ADD;
          end
          FN_AND: begin
            instClass = AluReg;
            execAluOp = ALU_AND;
          end
          FN_SUB: begin
            instClass = AluReg;
            execAluOp = ALU_SUB;
          end
          FN_SLT: begin
            instClass = AluReg;
            execAluOp = ALU_SLT;
          end
          FN_SLLV: begin
            instClass = ShiftVar;
            execAluOp = ALU_SHL_VAR;
          end
          FN_SRAV: begin
            instClass = ShiftVar;
            execAluOp = ALU_SRA_VAR;
          end
          FN_SLL: begin
            instClass = ShiftImm;
            execAluOp = ALU_SHL_IMM;
          end
          FN_SRA: begin
            instClass = ShiftImm;
            execAluOp = ALU_SRA_IMM;
          end
          FN_SRL: begin
            instClass = ShiftImm;
            execAluOp = ALU_SHR_IMM;
          end
          FN_JR: instClass = JumpReg;  // rs passes straight through
          default: ;
        endcase
      end
      OP_J:   instClass = Jump;
      OP_JAL: instClass = JumpLink;
      OP_BEQ: begin
        instClass = Branch;
        execAluOp = ALU_BEQ;
      end
      OP_BNE: begin
        instClass = Branch;
        execAluOp = ALU_BNE;
      end
      OP_BLE: begin
        instClass = Branch;
        execAluOp = ALU_BLE;
      end
      OP_BGT: begin
        instClass = Branch;
        execAluOp = ALU_BGT;
      end
      OP_ADDI, OP_ADDIU: begin
        instClass = AddImm;
        execAluOp = ALU_ADD;
      end
      default: ;
    endcase
  end

endmodule

// ==== logic/signalGenerator.sv ====
`timescale 1ns/1ns

module signalGenerator import ctrlPkg::*; (
  input  logic       clk,
  input  logic       reset_in,
  input  seqState_t  seqState,
  input  stepCount_t step,
  input  instClass_t heldClass,
  input  aluOp_t     heldAluOp,
  input  instClass_t instClass,
  output logic       resetOut,
  output logic       pcWrite,
  output logic       irWrite,
  output logic       aluOutWrite,
  output logic       regFileWrite,
  output logic       aRegWrite,
  output logic       bRegWrite,
  output muxSel_t    regDstSel,
  output muxSel_t    pcSrcSel,
  output muxSel_t    aluSrcASel,
  output muxSel_t    aluSrcBSel,
  output dataSel_t   regDataSel,
  output aluOp_t     aluOp
);

  logic       pcWriteNext, irWriteNext, aluOutWriteNext, regFileWriteNext;
  logic       aRegWriteNext, bRegWriteNext;
  muxSel_t    regDstSelNext, pcSrcSelNext, aluSrcASelNext, aluSrcBSelNext;
  dataSel_t   regDataSelNext;
  aluOp_t     aluOpNext;
  logic       lastFetch;
  stepCount_t writeStep;

  assign lastFetch = (step == stepCount_t'(FETCH_STEPS - 1));
  assign writeStep = (heldClass == ShiftVar) ? 3'd3 : 3'd2;

  always_comb begin
    pcWriteNext      = 1'b0;
    irWriteNext      = 1'b0;
    aluOutWriteNext  = 1'b0;
    regFileWriteNext = 1'b0;
    aRegWriteNext    = 1'b0;
    bRegWriteNext    = 1'b0;
    regDstSelNext    = DST_RT;
    pcSrcSelNext     = PC_FROM_ALU;
    aluSrcASelNext   = SRCA_PC;
    aluSrcBSelNext   = SRCB_REG;
    regDataSelNext   = WDATA_ALU;
    aluOpNext        = ALU_PASS_A;
    case (seqState)
      Fetch: begin
        if (step == 3'd0) begin  // Load IR, compute PC+4
          irWriteNext     = 1'b1;
          aluOutWriteNext = 1'b1;
          aluSrcASelNext  = SRCA_PC;
          aluSrcBSelNext  = SRCB_FOUR;
          aluOpNext       = ALU_ADD;
        end else if (lastFetch) begin
          pcWriteNext  = 1'b1;
          pcSrcSelNext = (instClass == Jump || instClass == JumpLink) ?
                         PC_FROM_JUMP : PC_FROM_ALUOUT;
          if (instClass == JumpLink) begin  // ra gets PC+4 already in ALUOut
            regFileWriteNext = 1'b1;
            regDstSelNext    = DST_RA;
            regDataSelNext   = WDATA_LINK;
          end
        end
      end
      Execute: begin
        case (heldClass)
          AluReg, ShiftVar, ShiftImm, AddImm: begin
            if (step == 3'd0) begin
              aRegWriteNext = (heldClass != ShiftImm);
              bRegWriteNext = (heldClass != AddImm);
            end else if (step <= writeStep) begin
              // Shift amount comes from the instruction, A unused
              if (heldClass != ShiftImm) aluSrcASelNext = SRCA_REG;
              aluSrcBSelNext = (heldClass == AddImm) ? SRCB_IMM : SRCB_REG;
              aluOpNext      = heldAluOp;
              if (step == writeStep) begin
                regFileWriteNext = 1'b1;
                regDstSelNext    = (heldClass == AddImm) ? DST_RT : DST_RD;
                regDataSelNext   = WDATA_ALU;
              end
            end
          end
          JumpReg: begin
            if (step == 3'd0) begin
              aRegWriteNext = 1'b1;
            end else if (step <= 3'd2) begin
              aluSrcASelNext = SRCA_REG;
              aluOpNext      = heldAluOp;  // Pass rs to PC
              if (step == 3'd2) begin
                pcWriteNext  = 1'b1;
                pcSrcSelNext = PC_FROM_ALU;
              end
            end
          end
          Branch: begin
            if (step == 3'd0) begin
              aRegWriteNext = 1'b1;
              bRegWriteNext = 1'b1;
            end else if (step == 3'd1) begin  // Compare
              aluSrcASelNext = SRCA_REG;
              aluSrcBSelNext = SRCB_REG;
              aluOpNext      = heldAluOp;
            end else if (step <= 3'd3) begin  // Target address
              aluSrcASelNext = SRCA_PC;
              aluSrcBSelNext = SRCB_BRANCH;
              aluOpNext      = ALU_ADD;
              if (step == 3'd3) begin
                pcWriteNext  = 1'b1;
                pcSrcSelNext = PC_FROM_ALU;
              end
            end
          end
          default: ;  // jal only waits out the link write
        endcase
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    resetOut <= reset_in;
    if (reset_in) begin
      pcWrite      <= 1'b0;
      irWrite      <= 1'b0;
      aluOutWrite  <= 1'b0;
      regFileWrite <= 1'b0;
      aRegWrite    <= 1'b0;
      bRegWrite    <= 1'b0;
      regDstSel    <= '0;
      pcSrcSel     <= '0;
      aluSrcASel   <= '0;
      aluSrcBSel   <= '0;
      regDataSel   <= '0;
      aluOp        <= '0;
    end else begin
      pcWrite      <= pcWriteNext;
      irWrite      <= irWriteNext;
      aluOutWrite  <= aluOutWriteNext;
      regFileWrite <= regFileWriteNext;
      aRegWrite    <= aRegWriteNext;
      bRegWrite    <= bRegWriteNext;
      regDstSel    <= regDstSelNext;
      pcSrcSel     <= pcSrcSelNext;
      aluSrcASel   <= aluSrcASelNext;
      aluSrcBSel   <= aluSrcBSelNext;
      regDataSel   <= regDataSelNext;
      aluOp        <= aluOpNext;
    end
  end

endmodule

// ==== sim/controlUnitTb.sv ====
`timescale 1ns/1ns

module controlUnitTb import ctrlPkg::*; ();

  localparam int NO_PC       = -1;  // No PC write in execute
  localparam int WR_NONE     = 0;
  localparam int WR_ALU      = 1;
  localparam int WR_LINK     = 2;
  localparam int WAIT_CYCLES = 16;  // Longest period is 9 cycles
  localparam int RANDOM_ROWS = 40;

  logic     clk;
  logic     reset_in;
  logic     updateUc;
  opcode_t  opcode;
  funct_t   funct;
  logic     resetOut, pcWrite, irWrite, aluOutWrite, regFileWrite, aRegWrite, bRegWrite;
  muxSel_t  regDstSel, pcSrcSel, aluSrcASel, aluSrcBSel;
  dataSel_t regDataSel;
  aluOp_t   aluOp;

  // Stimulus table, one entry per row in each queue
  string   rowName[$];
  opcode_t rowOp[$];
  funct_t  rowFn[$];
  logic    rowUc[$];
  int      rowN[$];
  aluOp_t  rowAlu[$];
  int      rowPc[$];
  int      rowWr[$];

  logic [15:0] lfsr;

  controlUnit u_dut (
    .clk         (clk),
    .reset_in    (reset_in),
    .updateUc    (updateUc),
    .opcode      (opcode),
    .funct       (funct),
    .resetOut    (resetOut),
    .pcWrite     (pcWrite),
    .irWrite     (irWrite),
    .aluOutWrite (aluOutWrite),
    .regFileWrite(regFileWrite),
    .aRegWrite   (aRegWrite),
    .bRegWrite   (bRegWrite),
    .regDstSel   (regDstSel),
    .pcSrcSel    (pcSrcSel),
    .aluSrcASel  (aluSrcASel),
    .aluSrcBSel  (aluSrcBSel),
    .regDataSel  (regDataSel),
    .aluOp       (aluOp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic addRow(input string name, input opcode_t op, input funct_t fn, input logic uc,
                        input int n, input aluOp_t alu, input int pc, input int wr);
    rowName.push_back(name);
    rowOp.push_back(op);
    rowFn.push_back(fn);
    rowUc.push_back(uc);
    rowN.push_back(n);
    rowAlu.push_back(alu);
    rowPc.push_back(pc);
    rowWr.push_back(wr);
  endtask

  task automatic stopWithError(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkValue(input string testName, input string what,
                            input int expected, input int actual);
    if (expected != actual)
      stopWithError($sformatf("error %s %s expected %0d actual %0d",
                              testName, what, expected, actual));
  endtask

  task automatic checkAssertions(input string testName);
    if (u_dut.u_chk.failCount != 0)
      stopWithError($sformatf("a bound assertion failed during %s", testName));
  endtask

  // Everything except resetOut must be idle
  task automatic checkQuiet(input string testName);
    checkValue(testName, "control outputs", 0,
               int'({pcWrite, irWrite, aluOutWrite, regFileWrite, aRegWrite, bRegWrite,
                     regDstSel, pcSrcSel, aluSrcASel, aluSrcBSel, regDataSel, aluOp}));
  endtask

  // Galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsrNext(input logic [15:0] state);
    if (state[0]) return (state >> 1) ^ 16'hB400;
    else return state >> 1;
  endfunction

  task automatic takeBits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      value = (value << 1) | int'(lfsr[0]);
      lfsr  = lfsrNext(lfsr);
    end
  endtask

  task automatic waitFirstFetch();
    int waited;
    waited = 0;
    while (!irWrite && waited < WAIT_CYCLES) begin
      checkQuiet("reset");
      checkAssertions("reset");
      waited++;
      @(negedge clk);
    end
    if (!irWrite) stopWithError("no instruction fetch started after reset");
  endtask

  // Entered at the irWrite pulse of the row's own fetch
  task automatic runRow(input int idx, input logic uc);
    string name;
    int    n, pc, wr, count, writes, pcWrites;
    logic  isBranch;
    logic  isJump;
    name     = rowName[idx];
    n        = rowN[idx];
    pc       = rowPc[idx];
    wr       = rowWr[idx];
    isBranch = rowOp[idx] inside {OP_BEQ, OP_BNE, OP_BLE, OP_BGT};
    isJump   = rowOp[idx] inside {OP_J, OP_JAL};
    if (isBranch && uc != rowUc[idx]) begin
      n  = uc ? 5 : 3;
      pc = uc ? int'(PC_FROM_ALU) : NO_PC;
    end
    @(posedge clk);
    opcode   <= rowOp[idx];
    funct    <= rowFn[idx];
    updateUc <= uc;
    writes   = 0;
    pcWrites = 0;
    count    = 1;
    @(negedge clk);
    while (!irWrite && count < WAIT_CYCLES) begin
      checkAssertions(name);
      if (regFileWrite) begin
        writes++;
        if (wr == WR_LINK) begin
          checkValue(name, "link destination", int'(DST_RA), int'(regDstSel));
          checkValue(name, "link data select", int'(WDATA_LINK), int'(regDataSel));
        end else if (wr == WR_ALU) begin
          checkValue(name, "write-step aluOp", int'(rowAlu[idx]), int'(aluOp));
          checkValue(name, "write data select", int'(WDATA_ALU), int'(regDataSel));
        end
      end
      if (isBranch && count == 4) begin  // Execute step 1 compare
        checkValue(name, "compare aluOp", int'(rowAlu[idx]), int'(aluOp));
      end
      if (count == 2) begin  // Fetch step 2 output
        checkValue(name, "fetch PC write", 1, int'(pcWrite));
        checkValue(name, "fetch PC source",
                   isJump ? int'(PC_FROM_JUMP) : int'(PC_FROM_ALUOUT), int'(pcSrcSel));
      end else if (pcWrite) begin
        pcWrites++;
        if (pc == NO_PC) stopWithError($sformatf("%s wrote the PC outside fetch", name));
        else checkValue(name, "PC source", pc, int'(pcSrcSel));
      end
      count++;
      @(negedge clk);
    end
    if (!irWrite) begin
      stopWithError($sformatf("%s: next fetch did not start in time", name));
    end else begin
      checkValue(name, "instruction period", 3 + n, count);
      checkValue(name, "register writes", (wr == WR_NONE) ? 0 : 1, writes);
      checkValue(name, "execute PC writes", (pc == NO_PC) ? 0 : 1, pcWrites);
      checkValue(name, "fetch ALUOut write", 1, int'(aluOutWrite));
      checkValue(name, "fetch aluOp", int'(ALU_ADD), int'(aluOp));
      checkValue(name, "fetch ALU B source", int'(SRCB_FOUR), int'(aluSrcBSel));
    end
  endtask

  initial begin
    int pick;
    int ucBit;
    reset_in = 1'b1;
    updateUc = 1'b0;
    opcode   = OP_RTYPE;
    funct    = FN_ADD;
    lfsr     = 16'd21008;

    addRow("add", OP_RTYPE, FN_ADD, 1'b0, 5, ALU_ADD, NO_PC, WR_ALU);
    addRow("and", OP_RTYPE, FN_AND, 1'b0, 5, ALU_AND, NO_PC, WR_ALU);
    addRow("sub", OP_RTYPE, FN_SUB, 1'b0, 5, ALU_SUB, NO_PC, WR_ALU);
    addRow("slt", OP_RTYPE, FN_SLT, 1'b0, 5, ALU_SLT, NO_PC, WR_ALU);
    addRow("sllv", OP_RTYPE, FN_SLLV, 1'b0, 6, ALU_SHL_VAR, NO_PC, WR_ALU);
    addRow("srav", OP_RTYPE, FN_SRAV, 1'b1, 6, ALU_SRA_VAR, NO_PC, WR_ALU);
    addRow("sll", OP_RTYPE, FN_SLL, 1'b0, 5, ALU_SHL_IMM, NO_PC, WR_ALU);
    addRow("sra", OP_RTYPE, FN_SRA, 1'b0, 5, ALU_SRA_IMM, NO_PC, WR_ALU);
    addRow("srl", OP_RTYPE, FN_SRL, 1'b1, 5, ALU_SHR_IMM, NO_PC, WR_ALU);
    addRow("jr", OP_RTYPE, FN_JR, 1'b0, 5, ALU_PASS_A, int'(PC_FROM_ALU), WR_NONE);
    addRow("j", OP_J, 6'h08, 1'b0, 0, ALU_PASS_A, NO_PC, WR_NONE);  // Target bits only
    addRow("jal", OP_JAL, 6'h2A, 1'b1, 2, ALU_PASS_A, NO_PC, WR_LINK);
    addRow("addi", OP_ADDI, 6'h15, 1'b0, 5, ALU_ADD, NO_PC, WR_ALU);
    addRow("addiu", OP_ADDIU, 6'h3C, 1'b0, 5, ALU_ADD, NO_PC, WR_ALU);
    addRow("beq_taken", OP_BEQ, 6'h01, 1'b1, 5, ALU_BEQ, int'(PC_FROM_ALU), WR_NONE);
    addRow("beq_not_taken", OP_BEQ, 6'h01, 1'b0, 3, ALU_BEQ, NO_PC, WR_NONE);
    addRow("bne_taken", OP_BNE, 6'h10, 1'b1, 5, ALU_BNE, int'(PC_FROM_ALU), WR_NONE);
    addRow("bne_not_taken", OP_BNE, 6'h10, 1'b0, 3, ALU_BNE, NO_PC, WR_NONE);
    addRow("ble_taken", OP_BLE, 6'h3F, 1'b1, 5, ALU_BLE, int'(PC_FROM_ALU), WR_NONE);
    addRow("ble_not_taken", OP_BLE, 6'h3F, 1'b0, 3, ALU_BLE, NO_PC, WR_NONE);
    addRow("bgt_taken", OP_BGT, 6'h20, 1'b1, 5, ALU_BGT, int'(PC_FROM_ALU), WR_NONE);
    addRow("bgt_not_taken", OP_BGT, 6'h20, 1'b0, 3, ALU_BGT, NO_PC, WR_NONE);
    addRow("bad_opcode", 6'h3F, 6'h00, 1'b1, 0, ALU_PASS_A, NO_PC, WR_NONE);
    addRow("bad_funct", OP_RTYPE, 6'h3F, 1'b0, 0, ALU_PASS_A, NO_PC, WR_NONE);

    @(posedge clk);
    @(negedge clk);
    checkValue("reset", "resetOut", 1, int'(resetOut));
    checkQuiet("reset");
    @(posedge clk);
    reset_in <= 1'b0;
    @(negedge clk);
    checkValue("reset", "resetOut", 1, int'(resetOut));  // Release not seen yet
    checkQuiet("reset");
    @(negedge clk);
    checkValue("release", "resetOut", 0, int'(resetOut));
    waitFirstFetch();

    for (int i = 0; i < rowName.size(); i++) runRow(i, rowUc[i]);

    for (int i = 0; i < RANDOM_ROWS; i++) begin
      takeBits(5, pick);
      takeBits(1, ucBit);
      runRow(pick % rowName.size(), ucBit[0]);
    end

    if (u_dut.u_chk.failCount == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      stopWithError("a bound assertion failed at the end of the run");
    end
  end

endmodule

// ==== sim/controlUnit_chk.sv ====
`timescale 1ns/1ns

module controlUnitChk import ctrlPkg::*; (
  input logic     clk,
  input logic     reset_in,
  input logic     resetOut,
  input logic     pcWrite,
  input logic     irWrite,
  input logic     aluOutWrite,
  input logic     regFileWrite,
  input logic     aRegWrite,
  input logic     bRegWrite,
  input muxSel_t  regDstSel,
  input muxSel_t  pcSrcSel,
  input muxSel_t  aluSrcASel,
  input muxSel_t  aluSrcBSel,
  input dataSel_t regDataSel,
  input aluOp_t   aluOp
);

  int   failCount = 0;  // Polled by the testbench
  logic anyControl;

  assign anyControl = pcWrite | irWrite | aluOutWrite | regFileWrite | aRegWrite | bRegWrite |
                      (|regDstSel) | (|pcSrcSel) | (|aluSrcASel) | (|aluSrcBSel) |
                      (|regDataSel) | (|aluOp);

  // IR load and register write belong to different cycles
  noFetchDuringWrite: assert property (@(posedge clk) disable iff (reset_in)
    !(irWrite && regFileWrite))
    else begin
      failCount++;
      $error("irWrite and regFileWrite high in the same cycle");
    end

  quietInReset: assert property (@(posedge clk) resetOut |-> !anyControl)
    else begin
      failCount++;
      $error("control output active while resetOut is high");
    end

  singlePcWrite: assert property (@(posedge clk) disable iff (reset_in)
    pcWrite |=> !pcWrite)
    else begin
      failCount++;
      $error("pcWrite high for two consecutive cycles");
    end

endmodule

bind controlUnit controlUnitChk u_chk (
  .clk         (clk),
  .reset_in    (reset_in),
  .resetOut    (resetOut),
  .pcWrite     (pcWrite),
  .irWrite     (irWrite),
  .aluOutWrite (aluOutWrite),
  .regFileWrite(regFileWrite),
  .aRegWrite   (aRegWrite),
  .bRegWrite   (bRegWrite),
  .regDstSel   (regDstSel),
  .pcSrcSel    (pcSrcSel),
  .aluSrcASel  (aluSrcASel),
  .aluSrcBSel  (aluSrcBSel),
  .regDataSel  (regDataSel),
  .aluOp       (aluOp)
);

// ==== verilog.f ====
logic/ctrlPkg.sv
logic/instDecoder.sv
logic/cycleSequencer.sv
logic/signalGenerator.sv
logic/controlUnit.sv
sim/controlUnit_chk.sv
sim/controlUnitTb.sv
